// File: Makefile
VERILATOR ?= verilator
FILELIST ?= build.f
TOP ?= tb_cpu
RTL_TOP ?= cpu_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= sim failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input lc3b_types::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f
);
	import lc3b_types::*;

	always_comb begin
		case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_not: f = ~a;
			// LEA, branch target
			alu_passb: f = b;
			default: f = b;
		endcase
	end

endmodule : alu

// File: build.f
lc3b_types.sv
control_rom.sv
regfile.sv
alu.sv
imem_ctrl.sv
dmem_ctrl.sv
datapath.sv
cpu_top.sv
tb_mem.sv
tb_cpu.sv

// File: control_rom.sv
`timescale 1ns/1ps

module control_rom (
	input lc3b_types::lc3b_instr ir,
	output lc3b_types::lc3b_control_word ctrl
);
	import lc3b_types::*;

	always_comb begin
		ctrl = nop_ctrl;
		case (ir.op.opcode)
			op_add: begin
				ctrl.opcode = op_add;
				ctrl.aluop = alu_add;
				ctrl.imm_sel = ir.op.imm_flag;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_and: begin
				ctrl.opcode = op_and;
				ctrl.aluop = alu_and;
				ctrl.imm_sel = ir.op.imm_flag;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_not: begin
				ctrl.opcode = op_not;
				ctrl.aluop = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_ldr: begin
				ctrl.opcode = op_ldr;
				ctrl.aluop = alu_add;
				ctrl.imm_sel = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_str: begin
				ctrl.opcode = op_str;
				ctrl.aluop = alu_add;
				ctrl.imm_sel = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// LEA leaves the condition codes alone in the LC-3b
			op_lea: begin
				ctrl.opcode = op_lea;
				ctrl.aluop = alu_passb;
				ctrl.offset_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
			end
			op_br: begin
				ctrl.opcode = op_br;
				ctrl.aluop = alu_passb;
				ctrl.offset_sel = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			default: ctrl = nop_ctrl;
		endcase
	end

endmodule : control_rom

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input logic clk,
	input logic rst,
	input logic mem_resp_0,
	input lc3b_types::lc3b_word mem_rdata_0,
	output lc3b_types::lc3b_word mem_address_0,
	output logic mem_read_0,
	input logic mem_resp_1,
	input lc3b_types::lc3b_word mem_rdata_1,
	output lc3b_types::lc3b_word mem_address_1,
	output lc3b_types::lc3b_word mem_wdata_1,
	output logic mem_read_1,
	output logic mem_write_1
);
	import lc3b_types::*;

	lc3b_word pc;
	lc3b_word ifetch_word;
	lc3b_word load_data;
	lc3b_word ex_result;
	lc3b_stage ex_stage;
	logic ifetch_ready;
	logic data_ready;
	logic stall;

	datapath datapath_i (
		.clk,
		.rst,
		.ifetch_word(ifetch_word),
		.ifetch_ready(ifetch_ready),
		.load_data(load_data),
		.data_ready(data_ready),
		.pc(pc),
		.stall(stall),
		.ex_stage(ex_stage),
		.ex_result(ex_result)
	);

	imem_ctrl imem_ctrl_i (
		.clk,
		.rst,
		.stall(stall),
		.pc(pc),
		.mem_resp(mem_resp_0),
		.mem_rdata(mem_rdata_0),
		.mem_address(mem_address_0),
		.mem_read(mem_read_0),
		.word(ifetch_word),
		.ready(ifetch_ready)
	);

	dmem_ctrl dmem_ctrl_i (
		.clk,
		.rst,
		.stall(stall),
		.ex_stage(ex_stage),
		.ex_result(ex_result),
		.mem_resp(mem_resp_1),
		.mem_rdata(mem_rdata_1),
		.mem_address(mem_address_1),
		.mem_wdata(mem_wdata_1),
		.mem_read(mem_read_1),
		.mem_write(mem_write_1),
		.load_data(load_data),
		.ready(data_ready)
	);

endmodule : cpu_top

// File: datapath.sv
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_word ifetch_word,
	input logic ifetch_ready,
	input lc3b_types::lc3b_word load_data,
	input logic data_ready,
	output lc3b_types::lc3b_word pc,
	output logic stall,
	output lc3b_types::lc3b_stage ex_stage,
	output lc3b_types::lc3b_word ex_result
);
	import lc3b_types::*;

	lc3b_instr ir;
	lc3b_word ir_pc;
	lc3b_word pc_plus2;
	lc3b_word pc_next;
	lc3b_control_word id_ctrl;
	lc3b_reg src_b;
	lc3b_word reg_a;
	lc3b_word reg_b;
	lc3b_word imm_next;
	lc3b_stage id_next;
	lc3b_stage id_stage;
	lc3b_stage mem_stage;
	lc3b_word target;
	lc3b_word alu_b;
	lc3b_word alu_f;
	lc3b_word mem_result;
	lc3b_nzp cc;
	lc3b_nzp cc_next;
	logic taken;

	assign stall = ~(ifetch_ready & data_ready);

	// Decode
	control_rom control_rom_i (
		.ir(ir),
		.ctrl(id_ctrl)
	);

	// STR reads its source through port b
	assign src_b = id_ctrl.mem_write ? ir.mem.dr_sr : ir.op.src2[2:0];

	regfile regfile_i (
		.clk,
		.rst,
		.load(mem_stage.ctrl.load_regfile && !stall),
		.dest(mem_stage.dest),
		.in(mem_result),
		.src_a(ir.op.sr1),
		.src_b(src_b),
		.reg_a(reg_a),
		.reg_b(reg_b)
	);

	always_comb begin
		if (id_ctrl.offset_sel) begin
			imm_next = {{6{ir.br.pcoffset9[8]}}, ir.br.pcoffset9, 1'b0};
		end else if (id_ctrl.mem_read || id_ctrl.mem_write) begin
			imm_next = {{9{ir.mem.offset6[5]}}, ir.mem.offset6, 1'b0};
		end else begin
			imm_next = {{11{ir.op.src2[4]}}, ir.op.src2};
		end
	end

	always_comb begin
		id_next.ctrl = id_ctrl;
		id_next.pc = ir_pc;
		id_next.sr1_val = reg_a;
		id_next.sr2_val = reg_b;
		id_next.imm = imm_next;
		id_next.dest = ir.op.dr;
		id_next.nzp = ir.br.nzp;
	end

	// Execute
	assign target = id_stage.pc + id_stage.imm;

	always_comb begin
		if (id_stage.ctrl.offset_sel) begin
			alu_b = target;
		end else if (id_stage.ctrl.imm_sel) begin
			alu_b = id_stage.imm;
		end else begin
			alu_b = id_stage.sr2_val;
		end
	end

	alu alu_i (
		.aluop(id_stage.ctrl.aluop),
		.a(id_stage.sr1_val),
		.b(alu_b),
		.f(alu_f)
	);

	// Resolved here, so two slots follow the branch
	assign taken = id_stage.ctrl.is_branch && ((id_stage.nzp & cc) != 3'b000);
	assign pc_plus2 = pc + 16'd2;
	assign pc_next = taken ? target : pc_plus2;

	// Writeback flags
	always_comb begin
		if (mem_result[15]) begin
			cc_next = 3'b100;
		end else if (mem_result == 16'h0000) begin
			cc_next = 3'b010;
		end else begin
			cc_next = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			ir <= '0;
			id_stage.ctrl <= nop_ctrl;
			ex_stage.ctrl <= nop_ctrl;
			mem_stage.ctrl <= nop_ctrl;
			cc <= '0;
		end else if (!stall) begin
			pc <= pc_next;
			ir <= ifetch_word;
			ir_pc <= pc_plus2;
			id_stage <= id_next;
			ex_stage <= id_stage;
			ex_result <= alu_f;
			mem_stage <= ex_stage;
			mem_result <= ex_stage.ctrl.wb_sel ? load_data : ex_result;
			if (mem_stage.ctrl.load_cc) begin
				cc <= cc_next;
			end
		end
	end

endmodule : datapath

// File: dmem_ctrl.sv
`timescale 1ns/1ps

module dmem_ctrl (
	input logic clk,
	input logic rst,
	input logic stall,
	input lc3b_types::lc3b_stage ex_stage,
	input lc3b_types::lc3b_word ex_result,
	input logic mem_resp,
	input lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_word mem_wdata,
	output logic mem_read,
	output logic mem_write,
	output lc3b_types::lc3b_word load_data,
	output logic ready
);

	logic access;
	logic done;

	assign access = ex_stage.ctrl.mem_read || ex_stage.ctrl.mem_write;

	assign mem_address = ex_result;
	assign mem_wdata = ex_stage.sr2_val;
	assign mem_read = ex_stage.ctrl.mem_read && !done;
	assign mem_write = ex_stage.ctrl.mem_write && !done;
	assign ready = !access || done;

	// Access finished, wait for the pipeline to move on
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else if (mem_resp && (mem_read || mem_write)) begin
			done <= 1'b1;
		end else if (!stall) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_resp && mem_read) begin
			load_data <= mem_rdata;
		end
	end

	a_data_addr_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && !mem_resp |=>
			$stable(mem_address) && $stable(mem_wdata));

	a_read_write_excl: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write));

endmodule : dmem_ctrl

// File: imem_ctrl.sv
`timescale 1ns/1ps

module imem_ctrl (
	input logic clk,
	input logic rst,
	input logic stall,
	input lc3b_types::lc3b_word pc,
	input logic mem_resp,
	input lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word mem_address,
	output logic mem_read,
	output lc3b_types::lc3b_word word,
	output logic ready
);

	assign mem_address = pc;

	// ready low is pending, ready high is held
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			mem_read <= 1'b0;
		end else if (ready) begin
			if (!stall) begin
				ready <= 1'b0;
				mem_read <= 1'b1;
			end
		end else if (mem_read && mem_resp) begin
			ready <= 1'b1;
			mem_read <= 1'b0;
		end else begin
			mem_read <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_read && mem_resp) begin
			word <= mem_rdata;
		end
	end

	// PC must not move under an open fetch
	a_fetch_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_read && !mem_resp |=> $stable(mem_address));

endmodule : imem_ctrl

// File: lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_passb
	} lc3b_aluop;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic imm_sel;
		logic offset_sel;
		logic mem_read;
		logic mem_write;
		logic wb_sel;
		logic load_regfile;
		logic load_cc;
		logic is_branch;
	} lc3b_control_word;

	// Operate format, src2 is imm5 or {2'bxx, sr2}
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] src2;
	} lc3b_op_fmt;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr_sr;
		lc3b_reg base;
		logic [5:0] offset6;
	} lc3b_mem_fmt;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_nzp nzp;
		logic [8:0] pcoffset9;
	} lc3b_br_fmt;

	typedef union packed {
		lc3b_op_fmt op;
		lc3b_mem_fmt mem;
		lc3b_br_fmt br;
	} lc3b_instr;

	typedef struct packed {
		lc3b_control_word ctrl;
		lc3b_word pc;
		lc3b_word sr1_val;
		lc3b_word sr2_val;
		lc3b_word imm;
		lc3b_reg dest;
		lc3b_nzp nzp;
	} lc3b_stage;

	localparam lc3b_word reset_pc = 16'h0000;

	localparam lc3b_control_word nop_ctrl = '{
		opcode: op_br,
		aluop: alu_add,
		imm_sel: 1'b0,
		offset_sel: 1'b0,
		mem_read: 1'b0,
		mem_write: 1'b0,
		wb_sel: 1'b0,
		load_regfile: 1'b0,
		load_cc: 1'b0,
		is_branch: 1'b0
	};

endpackage : lc3b_types

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic rst,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// Write in flight goes straight to the readers
	assign reg_a = (load && dest == src_a) ? in : regs[src_a];
	assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule : regfile

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import lc3b_types::*;

	typedef struct packed {
		lc3b_word addr;
		lc3b_word data;
	} store_row;

	localparam int prog_len = 49;
	localparam int row_count = 14;
	localparam int store_timeout = 2000;
	localparam int fetch_timeout = 2000;
	localparam int quiet_cycles = 200;
	localparam lc3b_word first_fetch_addr = 16'h0000;

	// Program at address 0 with two NOPs between a write and its readers
	lc3b_word program_words [prog_len] = '{
		16'hEA7F, 16'hECFE, 16'h1225, 16'h143D, 16'h0000, 16'h0000, 16'h1642, 16'h5842,
		16'h5EAE, 16'h92BF, 16'h7780, 16'h7981, 16'h7F82, 16'h7383, 16'h7584, 16'h6340,
		16'h6541, 16'h0000, 16'h7385, 16'h7586, 16'h0403, 16'h7787, 16'h0000, 16'h7988,
		16'h0803, 16'h7F89, 16'h738A, 16'h758B, 16'h1620, 16'h0000, 16'h0000, 16'h0403,
		16'h778C, 16'h0000, 16'h798D, 16'h1627, 16'h0000, 16'h0000, 16'h0203, 16'h778E,
		16'h0000, 16'h798F, 16'hE204, 16'h0000, 16'h0000, 16'h7390, 16'h0FFF, 16'h0000,
		16'h0000
	};

	// Stores relative to R6 = 0x0200 from LEA, one offset step per STR
	store_row exp_rows [row_count] = '{
		{16'h0200, 16'h0002},
		{16'h0202, 16'h0005},
		{16'h0204, 16'h000C},
		{16'h0206, 16'h0002},
		{16'h0208, 16'hFFFD},
		{16'h020A, 16'h1234},
		{16'h020C, 16'hBEEF},
		{16'h020E, 16'h0002},
		{16'h0210, 16'h0005},
		{16'h0212, 16'h000C},
		{16'h0214, 16'h1234},
		{16'h0218, 16'h0000},
		{16'h021C, 16'h0007},
		{16'h0220, 16'h005E}
	};

	string row_names [row_count] = '{
		"add_reg", "and_reg", "and_imm", "not", "add_imm", "ldr_pos", "ldr_neg",
		"brz_nt_slot", "brz_nt_fall", "brn_slot1", "brn_slot2", "brz_slot",
		"brp_slot", "lea"
	};

	logic clk;
	logic rst;
	logic mem_resp_0;
	lc3b_word mem_rdata_0;
	lc3b_word mem_address_0;
	logic mem_read_0;
	logic mem_resp_1;
	lc3b_word mem_rdata_1;
	lc3b_word mem_address_1;
	lc3b_word mem_wdata_1;
	logic mem_read_1;
	logic mem_write_1;

	int tests_run;
	int tests_failed;
	bit written [lc3b_word];

	cpu_top dut_i (
		.clk,
		.rst,
		.mem_resp_0,
		.mem_rdata_0,
		.mem_address_0,
		.mem_read_0,
		.mem_resp_1,
		.mem_rdata_1,
		.mem_address_1,
		.mem_wdata_1,
		.mem_read_1,
		.mem_write_1
	);

	tb_mem mem_i (
		.clk,
		.rst,
		.address_0(mem_address_0),
		.read_0(mem_read_0),
		.resp_0(mem_resp_0),
		.rdata_0(mem_rdata_0),
		.address_1(mem_address_1),
		.wdata_1(mem_wdata_1),
		.read_1(mem_read_1),
		.write_1(mem_write_1),
		.resp_1(mem_resp_1),
		.rdata_1(mem_rdata_1)
	);

	always #20 clk = ~clk;

	task automatic load_memory();
		for (int i = 0; i < prog_len; i++) begin
			mem_i.mem[i] = program_words[i];
		end
		// Load data at 0x0100 and 0x0102
		mem_i.mem[16'h0080] = 16'h1234;
		mem_i.mem[16'h0081] = 16'hBEEF;
	endtask

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (!ok) begin
			tests_failed++;
		end
		$display("test %-12s %s", name, ok ? "ok" : "FAILED");
	endtask

	task automatic wait_fetch(output bit ok);
		int n;
		n = 0;
		while (!mem_read_0 && n < fetch_timeout) begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = mem_read_0;
	endtask

	task automatic wait_store(output bit ok);
		int n;
		n = 0;
		while (mem_i.store_q.size() == 0 && n < store_timeout) begin
			@(posedge clk);
			#2;
			n++;
		end
		ok = (mem_i.store_q.size() != 0);
	endtask

	initial begin
		store_row got;
		bit ok;
		bit row_ok;
		bit timed_out;
		clk = 1'b0;
		rst = 1'b1;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		#1;
		load_memory();

		row_ok = 1'b1;
		repeat (16) begin
			@(posedge clk);
			#2;
			assert (!mem_read_0 && !mem_read_1 && !mem_write_1) else begin
				$display({"mismatch at %0t: in reset expected requests 000, ",
					"got read_0 %b read_1 %b write_1 %b"},
					$time, mem_read_0, mem_read_1, mem_write_1);
				row_ok = 1'b0;
			end
		end
		rst = 1'b0;
		report_test("reset", row_ok);

		row_ok = 1'b1;
		wait_fetch(ok);
		if (!ok) begin
			$display("failure at %0t: no instruction fetch after reset", $time);
			row_ok = 1'b0;
			timed_out = 1'b1;
		end else begin
			assert (mem_address_0 == first_fetch_addr) else begin
				$display("mismatch at %0t: first fetch expected %h, got %h",
					$time, first_fetch_addr, mem_address_0);
				row_ok = 1'b0;
			end
		end
		report_test("first_fetch", row_ok);

		for (int i = 0; i < row_count && !timed_out; i++) begin
			row_ok = 1'b1;
			wait_store(ok);
			if (!ok) begin
				$display("failure at %0t: %s store never arrived", $time, row_names[i]);
				row_ok = 1'b0;
				timed_out = 1'b1;
			end else begin
				got = mem_i.store_q.pop_front();
				assert (!written.exists(got.addr)) else begin
					$display("failure at %0t: address %h written twice", $time, got.addr);
					row_ok = 1'b0;
				end
				written[got.addr] = 1'b1;
				assert (got == exp_rows[i]) else begin
					$display("mismatch at %0t: %s expected [%h] = %h, got [%h] = %h",
						$time, row_names[i], exp_rows[i].addr, exp_rows[i].data,
						got.addr, got.data);
					row_ok = 1'b0;
				end
			end
			report_test(row_names[i], row_ok);
		end

		// Skipped slots and the final loop must stay silent
		if (!timed_out) begin
			row_ok = 1'b1;
			repeat (quiet_cycles) @(posedge clk);
			#2;
			assert (mem_i.store_q.size() == 0) else begin
				$display("failure at %0t: unexpected store to %h", $time,
					mem_i.store_q[0][31:16]);
				row_ok = 1'b0;
			end
			report_test("no_extra", row_ok);
		end

		$display("tests: %0d run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : tb_cpu

// File: tb_mem.sv
`timescale 1ns/1ps

module tb_mem (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_word address_0,
	input logic read_0,
	output logic resp_0,
	output lc3b_types::lc3b_word rdata_0,
	input lc3b_types::lc3b_word address_1,
	input lc3b_types::lc3b_word wdata_1,
	input logic read_1,
	input logic write_1,
	output logic resp_1,
	output lc3b_types::lc3b_word rdata_1
);
	import lc3b_types::*;

	// Word array, indexed by address[15:1]
	lc3b_word mem [32768];
	// Every completed write as {address, data}
	logic [31:0] store_q [$];

	int wait_0;
	int wait_1;
	logic busy_0;
	logic busy_1;
	logic resp_0_next;
	logic resp_1_next;
	lc3b_word rdata_0_next;
	lc3b_word rdata_1_next;

	initial begin
		void'($urandom(42));
		for (int i = 0; i < 32768; i++) begin
			mem[i] = 16'(i) ^ 16'h6b3d;
		end
		resp_0 = 1'b0;
		resp_1 = 1'b0;
		rdata_0 = '0;
		rdata_1 = '0;
		busy_0 = 1'b0;
		busy_1 = 1'b0;
		wait_0 = 0;
		wait_1 = 0;
	end

	always @(posedge clk) begin
		resp_0_next = 1'b0;
		resp_1_next = 1'b0;
		rdata_0_next = rdata_0;
		rdata_1_next = rdata_1;
		if (rst) begin
			busy_0 = 1'b0;
			busy_1 = 1'b0;
		end else begin
			// A request still high in its response cycle is the old one
			if (!resp_0) begin
				if (!busy_0 && read_0) begin
					busy_0 = 1'b1;
					wait_0 = $urandom % 4;
				end
				if (busy_0) begin
					if (wait_0 == 0) begin
						resp_0_next = 1'b1;
						rdata_0_next = mem[address_0[15:1]];
						busy_0 = 1'b0;
					end else begin
						wait_0 = wait_0 - 1;
					end
				end
			end
			if (!resp_1) begin
				if (!busy_1 && (read_1 || write_1)) begin
					busy_1 = 1'b1;
					wait_1 = $urandom % 4;
				end
				if (busy_1) begin
					if (wait_1 == 0) begin
						resp_1_next = 1'b1;
						busy_1 = 1'b0;
						if (write_1) begin
							mem[address_1[15:1]] = wdata_1;
							store_q.push_back({address_1, wdata_1});
						end else begin
							rdata_1_next = mem[address_1[15:1]];
						end
					end else begin
						wait_1 = wait_1 - 1;
					end
				end
			end
		end
		#1;
		resp_0 = resp_0_next;
		resp_1 = resp_1_next;
		rdata_0 = rdata_0_next;
		rdata_1 = rdata_1_next;
	end

endmodule : tb_mem
